//--- Makefile
# Verilator build and run for the memory-command link bridge
VERILATOR ?= verilator
TOP       ?= tb_mem_link
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "Errors found" $(LOG); then \
	  echo "test failed"; exit 1; \
	fi; \
	echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
+incdir+include
src/mem_link_pkg.sv
src/mem_wh_cmd_encode.sv
src/wh_flit_serializer.sv
src/wh_flit_deserializer.sv
src/mem_link_send.sv
src/mem_link_remote.sv
src/mem_link_top.sv
tb/tb_mem_link.sv

//--- include/mem_link_defs.svh
// ---------------------------------------------------------------------------
// widths and depths for the memory-command link, one configuration only
// flit width times max flits must cover the largest packet (97 bits)
// ---------------------------------------------------------------------------
`ifndef MEM_LINK_DEFS_SVH
`define MEM_LINK_DEFS_SVH

// link
`define MEM_LINK_FLIT_WIDTH 32
`define MEM_LINK_MAX_FLITS  4

// wormhole routing fields
`define MEM_LINK_CORD_WIDTH 4
`define MEM_LINK_CID_WIDTH  2
`define MEM_LINK_LEN_WIDTH  3

// memory message
`define MEM_LINK_ADDR_WIDTH 16
`define MEM_LINK_DATA_WIDTH 64
`define MEM_LINK_MEM_DEPTH  16

`endif

//--- src/mem_link_pkg.sv
// ---------------------------------------------------------------------------
// message, header and flit types for the memory-command link
// wh_hdr_t keeps dst cord in its lowest bits so routing sees it first
// ---------------------------------------------------------------------------
`default_nettype none

`include "mem_link_defs.svh"

package mem_link_pkg;

  typedef logic [`MEM_LINK_CORD_WIDTH-1:0] cord_t;
  typedef logic [`MEM_LINK_CID_WIDTH-1:0]  cid_t;
  typedef logic [`MEM_LINK_LEN_WIDTH-1:0]  len_t; // flit count minus one
  typedef logic [`MEM_LINK_ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [`MEM_LINK_DATA_WIDTH-1:0] mem_data_t;
  typedef logic [`MEM_LINK_FLIT_WIDTH-1:0] flit_t;

  typedef enum logic [1:0] {
    e_mem_rd      = 2'd0,
    e_mem_wr      = 2'd1,
    e_mem_rd_resp = 2'd2,
    e_mem_wr_resp = 2'd3
  } mem_msg_type_e;

  // memory header is {type, addr}
  localparam int mem_type_lsb  = `MEM_LINK_ADDR_WIDTH;
  localparam int mem_hdr_width = `MEM_LINK_ADDR_WIDTH + $bits(mem_msg_type_e);
  typedef logic [mem_hdr_width-1:0] mem_hdr_t;

  // routing header is {dst cid, src cid, src cord, len, dst cord}
  localparam int wh_dst_cord_lsb = 0;
  localparam int wh_len_lsb      = wh_dst_cord_lsb + `MEM_LINK_CORD_WIDTH;
  localparam int wh_src_cord_lsb = wh_len_lsb + `MEM_LINK_LEN_WIDTH;
  localparam int wh_src_cid_lsb  = wh_src_cord_lsb + `MEM_LINK_CORD_WIDTH;
  localparam int wh_dst_cid_lsb  = wh_src_cid_lsb + `MEM_LINK_CID_WIDTH;
  localparam int wh_hdr_width    = wh_dst_cid_lsb + `MEM_LINK_CID_WIDTH;
  typedef logic [wh_hdr_width-1:0] wh_hdr_t;

  // packet is {padding, data, mem header, routing header}
  localparam int pkt_mhdr_lsb = wh_hdr_width;
  localparam int pkt_data_lsb = pkt_mhdr_lsb + mem_hdr_width;
  typedef logic [`MEM_LINK_MAX_FLITS*`MEM_LINK_FLIT_WIDTH-1:0] wh_pkt_t;

  localparam int len_long  = `MEM_LINK_MAX_FLITS - 1;
  localparam int len_short = (pkt_data_lsb + `MEM_LINK_FLIT_WIDTH - 1) /
                             `MEM_LINK_FLIT_WIDTH - 1;

  // only writes and read responses carry a data word
  function automatic len_t msg_len(input mem_msg_type_e msg_type);
    if (msg_type == e_mem_wr || msg_type == e_mem_rd_resp) begin
      return len_t'(len_long);
    end
    return len_t'(len_short);
  endfunction

endpackage

`default_nettype wire

//--- src/mem_link_remote.sv
// ---------------------------------------------------------------------------
// remote memory endpoint, 16 words of 64 bits, cleared on reset
// address bits 6 to 3 pick the word, higher bits are ignored
// one command in service at a time, answered in the cycle it is held
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mem_link_defs.svh"

module mem_link_remote (
  input  wire                      clk_i,
  input  wire                      arst_n_i,
  input  wire                      cmd_link_v_i,
  input  wire mem_link_pkg::flit_t cmd_link_data_i,
  output logic                     cmd_link_ready_o,
  output logic                     resp_link_v_o,
  output mem_link_pkg::flit_t      resp_link_data_o,
  input  wire                      resp_link_ready_i
);

  import mem_link_pkg::*;

  localparam int idx_w   = $clog2(`MEM_LINK_MEM_DEPTH);
  localparam int word_lsb = $clog2(`MEM_LINK_DATA_WIDTH / 8);

  mem_data_t        mem_q [`MEM_LINK_MEM_DEPTH];
  wh_pkt_t          cmd_pkt;
  wh_pkt_t          resp_pkt;
  logic             cmd_v;
  logic             cmd_yumi;
  logic             resp_ready;
  wh_hdr_t          cmd_wh;
  wh_hdr_t          resp_wh;
  mem_hdr_t         cmd_mhdr;
  mem_hdr_t         resp_mhdr;
  mem_msg_type_e    cmd_type;
  mem_msg_type_e    resp_type;
  mem_addr_t        cmd_addr;
  mem_data_t        cmd_data;
  mem_data_t        resp_data;
  logic [idx_w-1:0] word_idx;

  wh_flit_deserializer u_cmd_deser (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .link_v_i     (cmd_link_v_i),
    .link_data_i  (cmd_link_data_i),
    .link_ready_o (cmd_link_ready_o),
    .pkt_o        (cmd_pkt),
    .v_o          (cmd_v),
    .yumi_i       (cmd_yumi)
  );

  assign cmd_wh   = cmd_pkt[wh_hdr_width-1:0];
  assign cmd_mhdr = cmd_pkt[pkt_mhdr_lsb +: mem_hdr_width];
  assign cmd_data = cmd_pkt[pkt_data_lsb +: `MEM_LINK_DATA_WIDTH];
  assign cmd_type = mem_msg_type_e'(cmd_mhdr[mem_type_lsb +: $bits(mem_msg_type_e)]);
  assign cmd_addr = cmd_mhdr[`MEM_LINK_ADDR_WIDTH-1:0];
  assign word_idx = cmd_addr[word_lsb +: idx_w];

  assign resp_type = (cmd_type == e_mem_wr) ? e_mem_wr_resp : e_mem_rd_resp;
  assign resp_data = (cmd_type == e_mem_wr) ? '0 : mem_q[word_idx];
  assign resp_mhdr = {resp_type, cmd_addr};

  // source and destination trade places on the way back
  assign resp_wh = {cmd_wh[wh_src_cid_lsb +: `MEM_LINK_CID_WIDTH],
                    cmd_wh[wh_dst_cid_lsb +: `MEM_LINK_CID_WIDTH],
                    cmd_wh[wh_dst_cord_lsb +: `MEM_LINK_CORD_WIDTH],
                    msg_len(resp_type),
                    cmd_wh[wh_src_cord_lsb +: `MEM_LINK_CORD_WIDTH]};

  assign resp_pkt = wh_pkt_t'({resp_data, resp_mhdr, resp_wh});
  assign cmd_yumi = cmd_v && resp_ready; // release only once the response is taken

  wh_flit_serializer u_resp_ser (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .pkt_i        (resp_pkt),
    .v_i          (cmd_v),
    .ready_o      (resp_ready),
    .link_v_o     (resp_link_v_o),
    .link_data_o  (resp_link_data_o),
    .link_ready_i (resp_link_ready_i)
  );

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `MEM_LINK_MEM_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (cmd_yumi && cmd_type == e_mem_wr) begin
      mem_q[word_idx] <= cmd_data;
    end
  end

endmodule

`default_nettype wire

//--- src/mem_link_send.sv
// ---------------------------------------------------------------------------
// sender bridge from the memory command/response side onto a link pair
// only read and write commands may enter, one beat per message
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mem_link_defs.svh"

module mem_link_send (
  input  wire                         clk_i,
  input  wire                         arst_n_i,
  input  wire mem_link_pkg::cord_t    my_cord_i,
  input  wire mem_link_pkg::cid_t     my_cid_i,
  input  wire mem_link_pkg::cord_t    dst_cord_i,
  input  wire mem_link_pkg::cid_t     dst_cid_i,
  input  wire mem_link_pkg::mem_hdr_t cmd_hdr_i,
  input  wire mem_link_pkg::mem_data_t cmd_data_i,
  input  wire                         cmd_v_i,
  output logic                        cmd_ready_o,
  output mem_link_pkg::mem_hdr_t      resp_hdr_o,
  output mem_link_pkg::mem_data_t     resp_data_o,
  output logic                        resp_v_o,
  input  wire                         resp_yumi_i,
  output logic                        cmd_link_v_o,
  output mem_link_pkg::flit_t         cmd_link_data_o,
  input  wire                         cmd_link_ready_i,
  input  wire                         resp_link_v_i,
  input  wire mem_link_pkg::flit_t    resp_link_data_i,
  output logic                        resp_link_ready_o
);

  import mem_link_pkg::*;

  wh_hdr_t cmd_wh_hdr;
  wh_pkt_t cmd_pkt;
  wh_pkt_t resp_pkt;

  mem_wh_cmd_encode u_encode (
    .cmd_hdr_i  (cmd_hdr_i),
    .src_cord_i (my_cord_i),
    .src_cid_i  (my_cid_i),
    .dst_cord_i (dst_cord_i),
    .dst_cid_i  (dst_cid_i),
    .wh_hdr_o   (cmd_wh_hdr)
  );

  assign cmd_pkt = wh_pkt_t'({cmd_data_i, cmd_hdr_i, cmd_wh_hdr}); // zero padded on top

  wh_flit_serializer u_cmd_ser (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .pkt_i        (cmd_pkt),
    .v_i          (cmd_v_i),
    .ready_o      (cmd_ready_o),
    .link_v_o     (cmd_link_v_o),
    .link_data_o  (cmd_link_data_o),
    .link_ready_i (cmd_link_ready_i)
  );

  wh_flit_deserializer u_resp_deser (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .link_v_i     (resp_link_v_i),
    .link_data_i  (resp_link_data_i),
    .link_ready_o (resp_link_ready_o),
    .pkt_o        (resp_pkt),
    .v_o          (resp_v_o),
    .yumi_i       (resp_yumi_i)
  );

  assign resp_hdr_o  = resp_pkt[pkt_mhdr_lsb +: mem_hdr_width];
  assign resp_data_o = resp_pkt[pkt_data_lsb +: `MEM_LINK_DATA_WIDTH];

  // responses are never sent upstream from this side
  a_cmd_type: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_v_i |-> cmd_hdr_i[mem_type_lsb +: $bits(mem_msg_type_e)] inside {e_mem_rd, e_mem_wr});

endmodule

`default_nettype wire

//--- src/mem_link_top.sv
// ---------------------------------------------------------------------------
// sender bridge tied straight to the remote memory endpoint
// the two links are point to point, no router in between
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_link_top (
  input  wire                          clk_i,
  input  wire                          arst_n_i,
  input  wire mem_link_pkg::cord_t     my_cord_i,
  input  wire mem_link_pkg::cid_t      my_cid_i,
  input  wire mem_link_pkg::cord_t     dst_cord_i,
  input  wire mem_link_pkg::cid_t      dst_cid_i,
  input  wire mem_link_pkg::mem_hdr_t  cmd_hdr_i,
  input  wire mem_link_pkg::mem_data_t cmd_data_i,
  input  wire                          cmd_v_i,
  output logic                         cmd_ready_o,
  output mem_link_pkg::mem_hdr_t       resp_hdr_o,
  output mem_link_pkg::mem_data_t      resp_data_o,
  output logic                         resp_v_o,
  input  wire                          resp_yumi_i
);

  import mem_link_pkg::*;

  logic  cmd_link_v;
  logic  cmd_link_ready;
  flit_t cmd_link_data;
  logic  resp_link_v;
  logic  resp_link_ready;
  flit_t resp_link_data;

  mem_link_send u_send (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .my_cord_i         (my_cord_i),
    .my_cid_i          (my_cid_i),
    .dst_cord_i        (dst_cord_i),
    .dst_cid_i         (dst_cid_i),
    .cmd_hdr_i         (cmd_hdr_i),
    .cmd_data_i        (cmd_data_i),
    .cmd_v_i           (cmd_v_i),
    .cmd_ready_o       (cmd_ready_o),
    .resp_hdr_o        (resp_hdr_o),
    .resp_data_o       (resp_data_o),
    .resp_v_o          (resp_v_o),
    .resp_yumi_i       (resp_yumi_i),
    .cmd_link_v_o      (cmd_link_v),
    .cmd_link_data_o   (cmd_link_data),
    .cmd_link_ready_i  (cmd_link_ready),
    .resp_link_v_i     (resp_link_v),
    .resp_link_data_i  (resp_link_data),
    .resp_link_ready_o (resp_link_ready)
  );

  mem_link_remote u_remote (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .cmd_link_v_i      (cmd_link_v),
    .cmd_link_data_i   (cmd_link_data),
    .cmd_link_ready_o  (cmd_link_ready),
    .resp_link_v_o     (resp_link_v),
    .resp_link_data_o  (resp_link_data),
    .resp_link_ready_i (resp_link_ready)
  );

endmodule

`default_nettype wire

//--- src/mem_wh_cmd_encode.sv
// ---------------------------------------------------------------------------
// builds the wormhole routing header for an outgoing memory command
// purely combinational, length follows the message type
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_wh_cmd_encode (
  input  wire mem_link_pkg::mem_hdr_t cmd_hdr_i,
  input  wire mem_link_pkg::cord_t    src_cord_i,
  input  wire mem_link_pkg::cid_t     src_cid_i,
  input  wire mem_link_pkg::cord_t    dst_cord_i,
  input  wire mem_link_pkg::cid_t     dst_cid_i,
  output mem_link_pkg::wh_hdr_t       wh_hdr_o
);

  import mem_link_pkg::*;

  mem_msg_type_e cmd_type;
  len_t          cmd_len;

  assign cmd_type = mem_msg_type_e'(cmd_hdr_i[mem_type_lsb +: $bits(mem_msg_type_e)]);
  assign cmd_len  = msg_len(cmd_type); // reads go short, writes go long

  // field order matches the offsets in the package
  assign wh_hdr_o = {dst_cid_i, src_cid_i, src_cord_i, cmd_len, dst_cord_i};

endmodule

`default_nettype wire

//--- src/wh_flit_deserializer.sv
// ---------------------------------------------------------------------------
// gathers link flits into one packet, count comes from the first flit
// the packet is held with v_o high until yumi, link ready stays low meanwhile
// bits past the last flit of a short packet read as zero
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mem_link_defs.svh"

module wh_flit_deserializer (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  wire                     link_v_i,
  input  wire mem_link_pkg::flit_t link_data_i,
  output logic                    link_ready_o,
  output mem_link_pkg::wh_pkt_t   pkt_o,
  output logic                    v_o,
  input  wire                     yumi_i
);

  import mem_link_pkg::*;

  localparam int cnt_w = $clog2(`MEM_LINK_MAX_FLITS);

  typedef enum logic {
    s_recv,
    s_hold
  } state_e;

  state_e           state_q;
  wh_pkt_t          pkt_q;
  logic [cnt_w-1:0] cnt_q;
  len_t             len_q;
  len_t             cur_len;
  logic             flit_acc;

  assign link_ready_o = (state_q == s_recv);
  assign v_o          = (state_q == s_hold);
  assign pkt_o        = pkt_q;
  assign flit_acc     = link_v_i && link_ready_o;

  // the first flit brings its own len, later flits use the stored one
  assign cur_len = (cnt_q == '0) ? link_data_i[wh_len_lsb +: `MEM_LINK_LEN_WIDTH] : len_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= s_recv;
      cnt_q   <= '0;
      len_q   <= '0;
    end else if (flit_acc) begin
      len_q <= cur_len;
      if (len_t'(cnt_q) == cur_len) begin
        state_q <= s_hold;
        cnt_q   <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (v_o && yumi_i) begin
      state_q <= s_recv;
    end
  end

  always_ff @(posedge clk_i) begin
    if (flit_acc) begin
      if (cnt_q == '0) begin
        pkt_q <= wh_pkt_t'(link_data_i); // clears what the last packet left
      end else begin
        pkt_q[cnt_q*`MEM_LINK_FLIT_WIDTH +: `MEM_LINK_FLIT_WIDTH] <= link_data_i;
      end
    end
  end

  a_yumi_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

//--- src/wh_flit_serializer.sv
// ---------------------------------------------------------------------------
// splits one packet into flits on a valid/ready link
// takes a new packet only when idle, len is read from the packet header
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mem_link_defs.svh"

module wh_flit_serializer (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  wire mem_link_pkg::wh_pkt_t pkt_i,
  input  wire                     v_i,
  output logic                    ready_o,
  output logic                    link_v_o,
  output mem_link_pkg::flit_t     link_data_o,
  input  wire                     link_ready_i
);

  import mem_link_pkg::*;

  typedef enum logic {
    s_idle,
    s_send
  } state_e;

  state_e  state_q;
  wh_pkt_t pkt_q;
  len_t    len_q;
  len_t    cnt_q;
  logic    pkt_acc;
  logic    flit_acc;

  assign ready_o     = (state_q == s_idle);
  assign link_v_o    = (state_q == s_send);
  assign link_data_o = pkt_q[`MEM_LINK_FLIT_WIDTH-1:0]; // lowest flit leaves first

  assign pkt_acc  = v_i && ready_o;
  assign flit_acc = link_v_o && link_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= s_idle;
      len_q   <= '0;
      cnt_q   <= '0;
    end else if (pkt_acc) begin
      state_q <= s_send;
      len_q   <= pkt_i[wh_len_lsb +: `MEM_LINK_LEN_WIDTH];
      cnt_q   <= '0;
    end else if (flit_acc) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == len_q) begin
        state_q <= s_idle; // free again on the last accepted flit
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pkt_acc) begin
      pkt_q <= pkt_i;
    end else if (flit_acc) begin
      pkt_q <= pkt_q >> `MEM_LINK_FLIT_WIDTH;
    end
  end

  // a stalled flit must not change under the receiver
  a_link_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    link_v_o && !link_ready_i |=> link_v_o && $stable(link_data_o));

endmodule

`default_nettype wire

//--- tb/tb_mem_link.sv
// ---------------------------------------------------------------------------
// directed testbench for the sender bridge joined to the remote memory
// expected responses come from a 16-word model kept in command order
// every wait gives up after timeout_cycles clock cycles
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mem_link_defs.svh"

module tb_mem_link;

  import mem_link_pkg::*;

  localparam int    timeout_cycles = 200;
  localparam cord_t my_cord        = 4'd1;
  localparam cid_t  my_cid         = 2'd0;
  localparam cord_t dst_cord       = 4'd5;
  localparam cid_t  dst_cid        = 2'd2;

  logic      clk = 1'b0;
  logic      arst_n;
  logic      cmd_v;
  mem_hdr_t  cmd_hdr;
  mem_data_t cmd_data;
  logic      cmd_ready;
  mem_hdr_t  resp_hdr;
  mem_data_t resp_data;
  logic      resp_v;
  logic      resp_yumi;

  mem_data_t   model [`MEM_LINK_MEM_DEPTH];
  mem_hdr_t    exp_hdr_q [$];
  mem_data_t   exp_data_q [$];
  logic [15:0] lfsr_q    = 16'd64847;
  int          check_cnt = 0;
  int          err_cnt   = 0;
  bit          timed_out = 1'b0; // once set, the remaining waits are skipped

  always #20 clk = ~clk;

  mem_link_top u_dut (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .my_cord_i   (my_cord),
    .my_cid_i    (my_cid),
    .dst_cord_i  (dst_cord),
    .dst_cid_i   (dst_cid),
    .cmd_hdr_i   (cmd_hdr),
    .cmd_data_i  (cmd_data),
    .cmd_v_i     (cmd_v),
    .cmd_ready_o (cmd_ready),
    .resp_hdr_o  (resp_hdr),
    .resp_data_o (resp_data),
    .resp_v_o    (resp_v),
    .resp_yumi_i (resp_yumi)
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // random bits around the word index, which sits in bits 6 to 3
  function automatic mem_addr_t word_addr(input logic [3:0] idx);
    logic [8:0] upper;
    logic [2:0] offset;
    upper  = 9'(rand_bits(9));
    offset = 3'(rand_bits(3));
    return {upper, idx, offset};
  endfunction

  task automatic finish_run();
    $display("checks run %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    err_cnt++;
    timed_out = 1'b1;
    $display("timeout at %0t ns while waiting for %s", $time, what);
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic send_cmd(input mem_hdr_t hdr, input mem_data_t data);
    int waited;
    if (timed_out) begin
      return;
    end
    waited = 0;
    @(posedge clk);
    cmd_v    <= 1'b1;
    cmd_hdr  <= hdr;
    cmd_data <= data;
    @(negedge clk);
    while (!cmd_ready && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (!cmd_ready) begin
      report_timeout("cmd_ready_o");
    end else begin
      @(posedge clk); // the command transfers on this edge
      cmd_v <= 1'b0;
    end
  endtask

  // queues the expected response, then sends the command
  task automatic issue(input mem_msg_type_e typ, input mem_addr_t addr, input mem_data_t data);
    logic [3:0] idx;
    idx = addr[6:3];
    if (typ == e_mem_wr) begin
      model[idx] = data;
      exp_hdr_q.push_back(mem_hdr_t'({e_mem_wr_resp, addr}));
      exp_data_q.push_back('0); // write responses carry no data
    end else begin
      exp_hdr_q.push_back(mem_hdr_t'({e_mem_rd_resp, addr}));
      exp_data_q.push_back(model[idx]);
    end
    send_cmd(mem_hdr_t'({typ, addr}), data);
  endtask

  task automatic get_resp(input int hold);
    mem_hdr_t  exp_hdr;
    mem_data_t exp_data;
    int        waited;
    if (timed_out) begin
      return;
    end
    exp_hdr  = exp_hdr_q.pop_front();
    exp_data = exp_data_q.pop_front();
    waited   = 0;
    @(negedge clk);
    while (!resp_v && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (!resp_v) begin
      report_timeout("resp_v_o");
    end else begin
      check_eq("resp_hdr_o", 64'(resp_hdr), 64'(exp_hdr));
      check_eq("resp_data_o", resp_data, exp_data);
      for (int i = 0; i < hold; i++) begin
        @(negedge clk);
        check_eq("resp_v_o", 64'(resp_v), 64'(1'b1));
        check_eq("resp_hdr_o", 64'(resp_hdr), 64'(exp_hdr));
        check_eq("resp_data_o", resp_data, exp_data);
      end
      @(posedge clk);
      resp_yumi <= 1'b1;
      @(posedge clk);
      resp_yumi <= 1'b0;
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_eq("cmd_ready_o", 64'(cmd_ready), 64'(1'b1));
    check_eq("resp_v_o", 64'(resp_v), 64'(1'b0));
  endtask

  task automatic test_write_read();
    mem_addr_t addr;
    addr = word_addr(4'd5);
    issue(e_mem_wr, addr, rand_bits(64));
    get_resp(0);
    issue(e_mem_rd, addr, '0);
    get_resp(0);
  endtask

  task automatic test_all_words();
    // a few reads first, most of memory is still zero here
    for (int i = 0; i < 4; i++) begin
      issue(e_mem_rd, word_addr(4'(rand_bits(4))), '0);
      get_resp(0);
    end
    for (int i = 0; i < `MEM_LINK_MEM_DEPTH; i++) begin
      issue(e_mem_wr, word_addr(4'(i)), rand_bits(64));
      get_resp(0);
    end
    for (int i = 0; i < `MEM_LINK_MEM_DEPTH; i++) begin
      issue(e_mem_rd, word_addr(4'(rand_bits(4))), '0);
      get_resp(0);
    end
  endtask

  task automatic test_back_to_back();
    mem_addr_t addr_a;
    mem_addr_t addr_b;
    addr_a = word_addr(4'd2);
    addr_b = word_addr(4'd11);
    issue(e_mem_wr, addr_a, rand_bits(64));
    issue(e_mem_wr, addr_b, rand_bits(64));
    issue(e_mem_rd, addr_a, '0);
    issue(e_mem_rd, addr_b, '0);
    for (int i = 0; i < 4; i++) begin
      get_resp(0);
    end
  endtask

  task automatic test_stall();
    mem_addr_t addr;
    for (int i = 0; i < 3; i++) begin
      addr = word_addr(4'(rand_bits(4)));
      issue(e_mem_wr, addr, rand_bits(64));
      get_resp(int'(rand_bits(4)) + 1);
      issue(e_mem_rd, addr, '0);
      get_resp(int'(rand_bits(4)) + 1);
    end
  endtask

  initial begin
    arst_n    = 1'b0;
    cmd_v     = 1'b0;
    cmd_hdr   = '0;
    cmd_data  = '0;
    resp_yumi = 1'b0;
    for (int i = 0; i < `MEM_LINK_MEM_DEPTH; i++) begin
      model[i] = '0;
    end
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    test_reset_state();
    test_write_read();
    test_all_words();
    test_back_to_back();
    test_stall();
    finish_run();
  end

endmodule

`default_nettype wire
